//--- common/profiler_defs.svh
// widths, opcodes, configuration map and stack depth, included by the package and the RTL
`ifndef PROFILER_DEFS_SVH
`define PROFILER_DEFS_SVH

// function number, also the hash output and the counter index
`define FUNC_W 8

// stack entries above the root function
`define STACK_DEPTH 16

// configuration port
`define CFG_ADDR_W 7
`define CFG_V1_ADDR 7'd0
`define CFG_SHIFT_ADDR 7'd1
// set for table writes, low six bits give the table word
`define CFG_TAB_BIT 6

// instruction decode
`define OPC_CALL 6'b000011
`define INSTR_RET 32'h03E00008

`endif

//--- common/profiler_pkg.sv
// shared types of the function profiler, imported by every RTL block and the testbench
`default_nettype none

package profiler_pkg;

	`include "profiler_defs.svh"

	typedef logic [31:0] pc_t;                // instruction address
	typedef logic [31:0] instr_t;             // raw instruction word
	typedef logic [`FUNC_W-1:0] func_num_t;   // hashed function number
	typedef logic [31:0] count_t;             // per-function instruction count

	// 0..16, root only at 0
	typedef logic [4:0] stack_ptr_t;

	// configuration port
	typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;
	typedef logic [31:0] cfg_data_t;
	typedef logic [7:0] hash_param_t;         // shift amount or mask

	// trace handshake FSM
	typedef enum logic [0:0] {
		DEC_IDLE,
		DEC_ACK
	} dec_state_t;

endpackage

`default_nettype wire

//--- address_hash/hash_table_ram.sv
// hash lookup table written as 32-bit words from the config port and read one byte at a time
`timescale 1ns/1ns
`default_nettype none

module hash_table_ram (
	input wire clk,

	input wire wr_en,
	input wire [5:0] wr_word,
	input wire profiler_pkg::cfg_data_t wr_data,

	input wire profiler_pkg::func_num_t rd_index,
	output profiler_pkg::func_num_t rd_byte
);

	import profiler_pkg::*;

	cfg_data_t mem [64];     // 64 words of four bytes
	func_num_t rd_index_q;   // registered read address
	cfg_data_t rd_word;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_word] <= wr_data;
		rd_index_q <= rd_index;
	end

	// byte 4w sits in bits 7:0 of word w
	assign rd_word = mem[rd_index_q[7:2]];
	assign rd_byte = rd_word[{rd_index_q[1:0], 3'b000} +: 8];

endmodule

`default_nettype wire

//--- address_hash/address_hash.sv
// four-stage perfect-hash pipeline mapping call targets to function numbers, strobes delayed alongside
`timescale 1ns/1ns
`include "profiler_defs.svh"
`default_nettype none

module address_hash (
	input wire clk,
	input wire reset,

	input wire call_strobe,
	input wire retn_strobe,
	input wire cnt_strobe,
	input wire profiler_pkg::pc_t call_target,

	input wire cfg_wr_en,
	input wire profiler_pkg::cfg_addr_t cfg_wr_addr,
	input wire profiler_pkg::cfg_data_t cfg_wr_data,

	output logic func_call,
	output logic func_retn,
	output logic func_cnt,
	output profiler_pkg::func_num_t func_num
);

	import profiler_pkg::*;

	// hash parameters
	cfg_data_t v1_param;
	hash_param_t a1, a2, b1, b2;

	// strobe delay lines, bit 3 is the output
	logic [3:0] call_sr;
	logic [3:0] retn_sr;
	logic [3:0] cnt_sr;

	// datapath
	pc_t hash_addr;          // stage 1
	logic [31:0] val;        // stage 2
	logic [31:0] a_val;      // stage 3
	logic [31:0] v1_sum;
	logic [31:0] v2_sum;
	logic [31:0] val_next;
	logic [31:0] tab_idx;
	logic [31:0] a_shift;
	func_num_t tab_byte;
	logic tab_wr_en;

	always_ff @(posedge clk) begin
		if (reset) begin
			v1_param <= '0;
			{a1, a2, b1, b2} <= '0;
		end else if (cfg_wr_en && !cfg_wr_addr[`CFG_TAB_BIT]) begin
			if (cfg_wr_addr == `CFG_V1_ADDR)
				v1_param <= cfg_wr_data;
			else if (cfg_wr_addr == `CFG_SHIFT_ADDR)
				{a1, a2, b1, b2} <= cfg_wr_data;   // A1 in the top byte
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			call_sr <= '0;
			retn_sr <= '0;
			cnt_sr <= '0;
		end else begin
			call_sr <= {call_sr[2:0], call_strobe};
			retn_sr <= {retn_sr[2:0], retn_strobe};
			cnt_sr <= {cnt_sr[2:0], cnt_strobe};
		end
	end

	assign func_call = call_sr[3];
	assign func_retn = retn_sr[3];
	assign func_cnt = cnt_sr[3];

	// mixing step of stage 2
	assign v1_sum = hash_addr + v1_param;
	assign v2_sum = v1_sum + (v1_sum << 8);
	assign val_next = v2_sum ^ (v2_sum >> 4);

	// table index from stage 2, byte comes back with stage 3
	assign tab_idx = (val >> b1) & {24'd0, b2};
	assign a_shift = a_val >> a2;

	always_ff @(posedge clk) begin
		if (call_strobe)
			hash_addr <= {6'd0, call_target[25:0]};   // only calls move the address
		val <= val_next;
		a_val <= val + (val << a1);
		func_num <= a_shift[7:0] ^ tab_byte;
	end

	assign tab_wr_en = cfg_wr_en & cfg_wr_addr[`CFG_TAB_BIT];

	hash_table_ram u_hash_table_ram (
		.clk      (clk),
		.wr_en    (tab_wr_en),
		.wr_word  (cfg_wr_addr[5:0]),
		.wr_data  (cfg_wr_data),
		.rd_index (tab_idx[7:0]),
		.rd_byte  (tab_byte)
	);

endmodule

`default_nettype wire

//--- verilog/trace_decoder.sv
// four-phase trace receiver, turns each accepted instruction into call, return and count strobes
`timescale 1ns/1ns
`include "profiler_defs.svh"
`default_nettype none

module trace_decoder (
	input wire clk,
	input wire reset,

	input wire trace_req,
	input wire profiler_pkg::pc_t trace_pc,
	input wire profiler_pkg::instr_t trace_instr,
	output logic trace_ack,

	output logic call_strobe,
	output logic retn_strobe,
	output logic cnt_strobe,
	output profiler_pkg::pc_t call_target
);

	import profiler_pkg::*;

	dec_state_t state;

	logic is_call;
	logic is_retn;

	assign is_call = (trace_instr[31:26] == `OPC_CALL);
	assign is_retn = (trace_instr == `INSTR_RET);

	// ack follows the state, high for the whole acknowledged phase
	assign trace_ack = (state == DEC_ACK);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= DEC_IDLE;
			call_strobe <= 1'b0;
			retn_strobe <= 1'b0;
			cnt_strobe <= 1'b0;
		end else begin
			// strobes are single pulses
			call_strobe <= 1'b0;
			retn_strobe <= 1'b0;
			cnt_strobe <= 1'b0;
			case (state)
				DEC_IDLE: begin
					if (trace_req) begin
						state <= DEC_ACK;
						cnt_strobe <= 1'b1;     // every instruction counts
						call_strobe <= is_call;
						retn_strobe <= is_retn;
					end
				end
				DEC_ACK: begin
					if (!trace_req)
						state <= DEC_IDLE;      // source released, drop ack
				end
				default: state <= DEC_IDLE;
			endcase
		end
	end

	// jump target, region bits of pc plus word index of the instruction
	always_ff @(posedge clk) begin
		if (state == DEC_IDLE && trace_req)
			call_target <= {trace_pc[31:28], trace_instr[25:0], 2'b00};
	end

endmodule

`default_nettype wire

//--- verilog/call_stack_profiler.sv
// call stack of active functions with per-function instruction counters and counter readout
`timescale 1ns/1ns
`include "profiler_defs.svh"
`default_nettype none

module call_stack_profiler (
	input wire clk,
	input wire reset,

	input wire func_call,
	input wire func_retn,
	input wire func_cnt,
	input wire profiler_pkg::func_num_t func_num,

	input wire profiler_pkg::func_num_t cnt_rd_addr,
	output profiler_pkg::count_t cnt_rd_data,

	output profiler_pkg::func_num_t cur_func,
	output profiler_pkg::stack_ptr_t stack_depth,
	output logic stack_overflow,
	output logic stack_underflow
);

	import profiler_pkg::*;

	// callers saved here, entry d holds the function below depth d+1
	func_num_t stack_mem [`STACK_DEPTH];

	count_t counters [256];
	logic [255:0] cnt_valid;   // cleared on reset, an invalid counter reads as 0

	stack_ptr_t depth_dec;
	logic stack_full;
	logic stack_empty;
	count_t cur_count;

	assign stack_full = (stack_depth == 5'(`STACK_DEPTH));
	assign stack_empty = (stack_depth == '0);
	assign depth_dec = stack_depth - 5'd1;
	assign cur_count = cnt_valid[cur_func] ? counters[cur_func] : '0;

	// stack control
	always_ff @(posedge clk) begin
		if (reset) begin
			stack_depth <= '0;
			cur_func <= '0;          // root function
			stack_overflow <= 1'b0;
			stack_underflow <= 1'b0;
		end else if (func_call) begin
			if (stack_full) begin
				stack_overflow <= 1'b1;   // sticky, push dropped
			end else begin
				stack_depth <= stack_depth + 5'd1;
				cur_func <= func_num;
			end
		end else if (func_retn) begin
			if (stack_empty) begin
				stack_underflow <= 1'b1;  // nothing to pop
			end else begin
				stack_depth <= depth_dec;
				cur_func <= stack_mem[depth_dec[3:0]];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (func_call && !stack_full)
			stack_mem[stack_depth[3:0]] <= cur_func;
	end

	// counting uses cur_func before this cycle's push or pop
	always_ff @(posedge clk) begin
		if (reset)
			cnt_valid <= '0;
		else if (func_cnt)
			cnt_valid[cur_func] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (func_cnt)
			counters[cur_func] <= cur_count + 32'd1;
	end

	// one cycle readout
	always_ff @(posedge clk) begin
		cnt_rd_data <= cnt_valid[cnt_rd_addr] ? counters[cnt_rd_addr] : '0;
	end

endmodule

`default_nettype wire

//--- verilog/profiler_top.sv
// function profiler top level, trace decoder into hash pipeline into call-stack profiler
`timescale 1ns/1ns
`default_nettype none

module profiler_top (
	input wire clk,
	input wire reset,

	input wire trace_req,
	input wire profiler_pkg::pc_t trace_pc,
	input wire profiler_pkg::instr_t trace_instr,
	output logic trace_ack,

	input wire cfg_wr_en,
	input wire profiler_pkg::cfg_addr_t cfg_wr_addr,
	input wire profiler_pkg::cfg_data_t cfg_wr_data,

	input wire profiler_pkg::func_num_t cnt_rd_addr,
	output profiler_pkg::count_t cnt_rd_data,

	output profiler_pkg::func_num_t cur_func,
	output profiler_pkg::stack_ptr_t stack_depth,
	output logic stack_overflow,
	output logic stack_underflow
);

	import profiler_pkg::*;

	// decoder strobes
	logic call_strobe;
	logic retn_strobe;
	logic cnt_strobe;
	pc_t call_target;

	// hash outputs, four cycles behind the strobes
	logic func_call;
	logic func_retn;
	logic func_cnt;
	func_num_t func_num;

	trace_decoder u_trace_decoder (
		.clk         (clk),
		.reset       (reset),
		.trace_req   (trace_req),
		.trace_pc    (trace_pc),
		.trace_instr (trace_instr),
		.trace_ack   (trace_ack),
		.call_strobe (call_strobe),
		.retn_strobe (retn_strobe),
		.cnt_strobe  (cnt_strobe),
		.call_target (call_target)
	);

	address_hash u_address_hash (
		.clk         (clk),
		.reset       (reset),
		.call_strobe (call_strobe),
		.retn_strobe (retn_strobe),
		.cnt_strobe  (cnt_strobe),
		.call_target (call_target),
		.cfg_wr_en   (cfg_wr_en),
		.cfg_wr_addr (cfg_wr_addr),
		.cfg_wr_data (cfg_wr_data),
		.func_call   (func_call),
		.func_retn   (func_retn),
		.func_cnt    (func_cnt),
		.func_num    (func_num)
	);

	call_stack_profiler u_call_stack_profiler (
		.clk             (clk),
		.reset           (reset),
		.func_call       (func_call),
		.func_retn       (func_retn),
		.func_cnt        (func_cnt),
		.func_num        (func_num),
		.cnt_rd_addr     (cnt_rd_addr),
		.cnt_rd_data     (cnt_rd_data),
		.cur_func        (cur_func),
		.stack_depth     (stack_depth),
		.stack_overflow  (stack_overflow),
		.stack_underflow (stack_underflow)
	);

endmodule

`default_nettype wire

//--- tb/tb_profiler.sv
// directed testbench for profiler_top, drives trace and config ports and checks a reference model
`timescale 1ns/1ns
`include "profiler_defs.svh"
`default_nettype none

module tb_profiler;

	import profiler_pkg::*;

	localparam int ACK_TIMEOUT = 20;
	localparam logic [1:0] KIND_CALL = 2'd0;
	localparam logic [1:0] KIND_RET = 2'd1;
	localparam logic [1:0] KIND_PLAIN = 2'd2;

	logic clk;
	logic reset;
	logic trace_req;
	pc_t trace_pc;
	instr_t trace_instr;
	logic trace_ack;
	logic cfg_wr_en;
	cfg_addr_t cfg_wr_addr;
	cfg_data_t cfg_wr_data;
	func_num_t cnt_rd_addr;
	count_t cnt_rd_data;
	func_num_t cur_func;
	stack_ptr_t stack_depth;
	logic stack_overflow;
	logic stack_underflow;

	integer seed;

	// copies of the configured hash parameters
	cfg_data_t v1_cfg;
	hash_param_t a1_cfg, a2_cfg, b1_cfg, b2_cfg;
	cfg_data_t tab_words [64];

	// model stack and counters
	func_num_t model_stack [`STACK_DEPTH];
	stack_ptr_t model_depth;
	func_num_t model_cur;
	count_t model_counts [256];
	logic [255:0] touched;
	logic model_ovf;
	logic model_unf;
	func_num_t last_hash;

	profiler_top u_profiler_top (
		.clk             (clk),
		.reset           (reset),
		.trace_req       (trace_req),
		.trace_pc        (trace_pc),
		.trace_instr     (trace_instr),
		.trace_ack       (trace_ack),
		.cfg_wr_en       (cfg_wr_en),
		.cfg_wr_addr     (cfg_wr_addr),
		.cfg_wr_data     (cfg_wr_data),
		.cnt_rd_addr     (cnt_rd_addr),
		.cnt_rd_data     (cnt_rd_data),
		.cur_func        (cur_func),
		.stack_depth     (stack_depth),
		.stack_overflow  (stack_overflow),
		.stack_underflow (stack_underflow)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic compare_func(input string test, input func_num_t exp, input func_num_t act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %0d, actual %0d", test, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_count(input string test, input count_t exp, input count_t act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %0d, actual %0d", test, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_depth(input string test, input stack_ptr_t exp, input stack_ptr_t act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %0d, actual %0d", test, exp, act);
			abort_run();
		end
	endtask

	task automatic compare_flag(input string test, input bit exp, input bit act);
		if (exp !== act) begin
			$display("MISMATCH %s: expected %0b, actual %0b", test, exp, act);
			abort_run();
		end
	endtask

	task automatic write_cfg(input cfg_addr_t addr, input cfg_data_t data);
		@(negedge clk);
		cfg_wr_en = 1'b1;
		cfg_wr_addr = addr;
		cfg_wr_data = data;
		@(negedge clk);
		cfg_wr_en = 1'b0;
	endtask

	function automatic func_num_t hash_model(input pc_t target);
		logic [31:0] v1, v2, val, idx, a, sh, tab_word;
		v1 = {6'd0, target[25:0]} + v1_cfg;
		v2 = v1 + (v1 << 8);
		val = v2 ^ (v2 >> 4);
		idx = (val >> b1_cfg) & {24'd0, b2_cfg};
		a = val + (val << a1_cfg);
		sh = a >> a2_cfg;
		tab_word = tab_words[idx[7:2]] >> {idx[1:0], 3'b000};   // byte 4w in bits 7:0
		return sh[7:0] ^ tab_word[7:0];
	endfunction

	// four-phase handshake, req up, ack up, req down, ack down
	task automatic send_instr(input pc_t pc, input instr_t instr);
		int cycles;
		@(negedge clk);
		trace_pc = pc;
		trace_instr = instr;
		trace_req = 1'b1;
		cycles = 0;
		while (trace_ack !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > ACK_TIMEOUT) begin
				$display("timeout: trace_ack never rose after trace_req");
				abort_run();
			end
		end
		trace_req = 1'b0;
		cycles = 0;
		while (trace_ack !== 1'b0) begin
			@(negedge clk);
			cycles++;
			if (cycles > ACK_TIMEOUT) begin
				$display("timeout: trace_ack never fell after trace_req dropped");
				abort_run();
			end
		end
	endtask

	task automatic settle_pipeline();
		for (int i = 0; i < 8; i++)
			@(negedge clk);
	endtask

	task automatic run_instr(input pc_t pc, input instr_t instr);
		pc_t target;
		target = {pc[31:28], instr[25:0], 2'b00};
		send_instr(pc, instr);
		model_counts[model_cur] = model_counts[model_cur] + 32'd1;   // charged before push/pop
		touched[model_cur] = 1'b1;
		if (instr[31:26] == `OPC_CALL) begin
			last_hash = hash_model(target);
			if (model_depth == 5'(`STACK_DEPTH)) begin
				model_ovf = 1'b1;
			end else begin
				model_stack[model_depth[3:0]] = model_cur;
				model_depth = model_depth + 5'd1;
				model_cur = last_hash;
			end
		end else if (instr == `INSTR_RET) begin
			if (model_depth == 5'd0) begin
				model_unf = 1'b1;
			end else begin
				model_depth = model_depth - 5'd1;
				model_cur = model_stack[model_depth[3:0]];
			end
		end
		settle_pipeline();
	endtask

	task automatic do_instr(input logic [1:0] kind);
		logic [31:0] rnd;
		pc_t pc;
		instr_t instr;
		rnd = $random(seed);
		pc = $random(seed);
		case (kind)
			KIND_CALL: instr = {`OPC_CALL, rnd[25:0]};
			KIND_RET: instr = `INSTR_RET;
			default: instr = {6'b001000, rnd[25:0]};   // addi, neither call nor return
		endcase
		run_instr(pc, instr);
	endtask

	task automatic read_count(input func_num_t addr, output count_t data);
		@(negedge clk);
		cnt_rd_addr = addr;
		@(negedge clk);
		data = cnt_rd_data;   // one cycle readout
	endtask

	task automatic check_state(input string test);
		compare_depth(test, model_depth, stack_depth);
		compare_func(test, model_cur, cur_func);
		compare_flag(test, model_ovf, stack_overflow);
		compare_flag(test, model_unf, stack_underflow);
	endtask

	task automatic check_counts(input string test);
		logic [8:0] i;
		count_t got;
		for (i = 0; i < 9'd256; i++) begin
			if (touched[i[7:0]]) begin
				read_count(i[7:0], got);
				compare_count(test, model_counts[i[7:0]], got);
			end
		end
	endtask

	task automatic test_reset();
		logic [8:0] i;
		count_t got;
		compare_flag("reset", 1'b0, trace_ack);
		compare_flag("reset", 1'b1, u_profiler_top.u_trace_decoder.state == DEC_IDLE);
		check_state("reset");
		for (i = 0; i < 9'd256; i = i + 9'd85) begin
			read_count(i[7:0], got);
			compare_count("reset", 32'd0, got);
		end
	endtask

	task automatic test_hash_mapping();
		logic [31:0] rnd;
		logic [6:0] w;
		v1_cfg = $random(seed);
		write_cfg(`CFG_V1_ADDR, v1_cfg);
		rnd = $random(seed);
		a1_cfg = {3'd0, rnd[28:24]};   // shifts kept to 0..31
		a2_cfg = {3'd0, rnd[20:16]};
		b1_cfg = {3'd0, rnd[12:8]};
		b2_cfg = rnd[7:0];
		write_cfg(`CFG_SHIFT_ADDR, {a1_cfg, a2_cfg, b1_cfg, b2_cfg});
		for (w = 0; w < 7'd64; w++) begin
			tab_words[w[5:0]] = $random(seed);
			write_cfg({1'b1, w[5:0]}, tab_words[w[5:0]]);   // bit 6 selects the table
		end
		repeat (6) begin
			do_instr(KIND_CALL);
			compare_func("hash", last_hash, cur_func);
			compare_depth("hash", 5'd1, stack_depth);
			do_instr(KIND_RET);
			compare_depth("hash", 5'd0, stack_depth);
		end
		check_counts("hash");
	endtask

	task automatic test_counting();
		do_instr(KIND_CALL);   // counts for root
		repeat (5) do_instr(KIND_PLAIN);
		do_instr(KIND_RET);    // counts for the callee
		repeat (3) do_instr(KIND_PLAIN);
		check_state("counting");
		check_counts("counting");
	endtask

	task automatic test_nesting();
		logic [31:0] rnd;
		repeat (40) begin
			rnd = $random(seed);
			if (rnd[1:0] == 2'd0 && model_depth < 5'd12)
				do_instr(KIND_CALL);
			else if (rnd[1:0] == 2'd1 && model_depth > 5'd0)
				do_instr(KIND_RET);
			else
				do_instr(KIND_PLAIN);
		end
		check_state("nesting");
		check_counts("nesting");
	endtask

	task automatic test_stack_errors();
		repeat (model_depth) do_instr(KIND_RET);   // back to root first
		repeat (17) do_instr(KIND_CALL);
		compare_flag("overflow", 1'b1, stack_overflow);
		compare_flag("overflow", 1'b0, stack_underflow);
		compare_depth("overflow", 5'd16, stack_depth);
		repeat (17) do_instr(KIND_RET);
		compare_flag("underflow", 1'b1, stack_underflow);
		compare_flag("underflow", 1'b1, stack_overflow);   // sticky
		compare_depth("underflow", 5'd0, stack_depth);
		check_state("stack errors");
		check_counts("stack errors");
	endtask

	initial begin
		logic [8:0] i;
		seed = 32'h8460;
		reset = 1'b1;
		trace_req = 1'b0;
		trace_pc = '0;
		trace_instr = '0;
		cfg_wr_en = 1'b0;
		cfg_wr_addr = '0;
		cfg_wr_data = '0;
		cnt_rd_addr = '0;
		model_depth = '0;
		model_cur = '0;
		model_ovf = 1'b0;
		model_unf = 1'b0;
		touched = '0;
		for (i = 0; i < 9'd256; i++)
			model_counts[i[7:0]] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset();
		test_hash_mapping();
		test_counting();
		test_nesting();
		test_stack_errors();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/profiler_pkg.sv
address_hash/hash_table_ram.sv
address_hash/address_hash.sv
verilog/trace_decoder.sv
verilog/call_stack_profiler.sv
verilog/profiler_top.sv
tb/tb_profiler.sv

//--- run_sim.sh
#!/bin/sh
# build the profiler testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_profiler -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_profiler)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
echo "pass message not found"
exit 1
